// File: all.f
rtl/rpRegPkg.sv
rtl/rpFuncPkg.sv
rtl/rpOpTimer.sv
rtl/rpErrReg.sv
rtl/rpStatusReg.sv
rtl/rpCmdFsm.sv
rtl/rpDrive.sv
sim/rpDriveTb.sv

// File: build.sh
#!/usr/bin/env bash
# Compile and run the drive testbench with Verilator
# Exit status is nonzero when the build, the run or the checks fail

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rpDriveTb \
   -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/VrpDriveTb > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
   echo "Simulation exited with status $runStatus"
   exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
   exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0

// File: rtl/rpCmdFsm.sv
////////////////////////////////////////////////////////////////////////////
// Function decoder and operation sequencer
// One operation in flight; a write while busy is refused, not queued
// Device reset drops a pending decode but a running operation completes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rpCmdFsm
   import rpRegPkg::*, rpFuncPkg::*;
(
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   devReset,
   input  wire                   funcWrite,
   input  wire rpFuncT           funcCode,
   input  wire                   go,
   input  wire                   wrl,
   input  wire rpDsT             ds,
   input  wire                   done,
   output logic                  start,
   output logic [TimerWidth-1:0] load,
   output rpCmdT                 cmd,
   output logic                  setIlf,
   output logic                  setWle,
   output logic                  setRmr,
   output logic                  pip,
   output logic                  dry
);

   typedef enum logic [1:0] {Idle, Position, Transfer} stateT;

   stateT state;
   stateT stateNext;
   rpCmdT cmdQ;
   rpCmdT cmdNext;
   logic  startNext;
   logic  setIlfNext;
   logic  setWleNext;
   logic  setRmrNext;
   logic  illegal;
   logic  accept;

   // Only writes with GO count
   assign accept = funcWrite & go & ~devReset;

   ////////////////////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      stateNext  = state;
      cmdNext    = '0;
      startNext  = 1'b0;
      setIlfNext = 1'b0;
      setWleNext = 1'b0;
      setRmrNext = 1'b0;
      illegal    = 1'b0;
      // Operation ends on timer expiry
      if (done)
         stateNext = Idle;
      if (accept)
      begin
         if (state != Idle)
         begin
            // Busy, refuse register modify
            setRmrNext     = 1'b1;
            cmdNext.setAta = 1'b1;
         end
         else if (ds.err)
         begin
            // Error present, only drive clear runs
            if (funcCode == FnDrvClr)
               cmdNext.drvClr = 1'b1;
            else
               cmdNext.goErr = 1'b1;
         end
         else
         begin
            case (funcCode)
               FnNop: ;
               FnSeek, FnRecal:
               begin
                  startNext = 1'b1;
                  stateNext = Position;
               end
               FnDrvClr: cmdNext.drvClr = 1'b1;
               FnPreset: cmdNext.preset = 1'b1;
               FnPakAck: cmdNext.pakAck = 1'b1;
               FnRead:
               begin
                  startNext      = 1'b1;
                  cmdNext.clrLst = 1'b1;
                  stateNext      = Transfer;
               end
               FnWrite:
               begin
                  if (wrl)
                  begin
                     // Locked pack, flag and do not run
                     setWleNext     = 1'b1;
                     cmdNext.setAta = 1'b1;
                  end
                  else
                  begin
                     startNext      = 1'b1;
                     cmdNext.clrLst = 1'b1;
                     stateNext      = Transfer;
                  end
               end
               FnUnload: illegal = 1'b1;
               default:  illegal = 1'b1;
            endcase
            if (illegal)
            begin
               setIlfNext     = 1'b1;
               cmdNext.setAta = 1'b1;
            end
         end
      end
   end

   // State and registered pulses
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state  <= Idle;
         cmdQ   <= '0;
         start  <= 1'b0;
         setIlf <= 1'b0;
         setWle <= 1'b0;
         setRmr <= 1'b0;
      end
      else
      begin
         state  <= stateNext;
         cmdQ   <= cmdNext;
         start  <= startNext;
         setIlf <= setIlfNext;
         setWle <= setWleNext;
         setRmr <= setRmrNext;
      end
   end

   // Completion pulses go out in the done cycle itself
   always_comb
   begin
      cmd        = cmdQ;
      cmd.setAta = cmdQ.setAta | (done & (state == Position));
      cmd.setLst = done & (state == Transfer);
   end

   // Timer load follows the operation just entered
   assign load = (state == Transfer) ? TimerWidth'(XferCycles) : TimerWidth'(SeekCycles);

   assign pip = (state == Position);
   assign dry = (state == Idle);

   // Start only when the status word showed the drive ready
   assert property (@(posedge clk) disable iff (rst) start |-> $past(ds.dry));

   // Timer expiry only while an operation runs
   assert property (@(posedge clk) disable iff (rst) done |-> state != Idle);

endmodule

`default_nettype wire

// File: rtl/rpDrive.sv
////////////////////////////////////////////////////////////////////////////
// RP-style drive as seen from the controller
// Function writes are one-clock strobes, no back-pressure
// mol, wrl and dpr are levels from the drive mechanics
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rpDrive
   import rpRegPkg::*, rpFuncPkg::*;
(
   input  wire         clk,
   input  wire         rst,
   input  wire         devReset,
   input  wire         funcWrite,
   input  wire rpFuncT funcCode,
   input  wire         go,
   input  wire         clrAta,
   input  wire         mol,
   input  wire         wrl,
   input  wire         dpr,
   output wire rpDsT   ds,
   output wire rpEr1T  er1
);

   // FSM to timer
   wire                  start;
   wire [TimerWidth-1:0] load;
   wire                  done;

   // FSM to registers
   wire rpCmdT           cmd;
   wire                  setIlf;
   wire                  setWle;
   wire                  setRmr;
   wire                  pip;
   wire                  dry;

   rpCmdFsm rpCmdFsm_i (
      .clk       (clk),
      .rst       (rst),
      .devReset  (devReset),
      .funcWrite (funcWrite),
      .funcCode  (funcCode),
      .go        (go),
      .wrl       (wrl),
      .ds        (ds),
      .done      (done),
      .start     (start),
      .load      (load),
      .cmd       (cmd),
      .setIlf    (setIlf),
      .setWle    (setWle),
      .setRmr    (setRmr),
      .pip       (pip),
      .dry       (dry)
   );

   rpOpTimer rpOpTimer_i (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .load  (load),
      .done  (done)
   );

   // Drive clear also empties ER1
   rpErrReg rpErrReg_i (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .drvClr   (cmd.drvClr),
      .setIlf   (setIlf),
      .setWle   (setWle),
      .setRmr   (setRmr),
      .er1      (er1)
   );

   rpStatusReg rpStatusReg_i (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .clrAta   (clrAta),
      .cmd      (cmd),
      .mol      (mol),
      .wrl      (wrl),
      .dpr      (dpr),
      .pip      (pip),
      .dry      (dry),
      .er1      (er1),
      .ds       (ds)
   );

endmodule

`default_nettype wire

// File: rtl/rpErrReg.sv
////////////////////////////////////////////////////////////////////////////
// First error register (ER1)
// Bits are sticky until drive clear or device reset
// Only ILF, RMR and WLE are implemented
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rpErrReg
   import rpRegPkg::*;
(
   input  wire   clk,
   input  wire   rst,
   input  wire   devReset,
   input  wire   drvClr,
   input  wire   setIlf,
   input  wire   setWle,
   input  wire   setRmr,
   output rpEr1T er1
);

   logic [15:0] errBits;

   // Clears win over sets in the same clock
   always_ff @(posedge clk)
   begin
      if (rst | devReset | drvClr)
      begin
         errBits <= '0;
      end
      else
      begin
         // Illegal function
         if (setIlf)
            errBits[Er1IlfBit] <= 1'b1;
         // Register modify refused
         if (setRmr)
            errBits[Er1RmrBit] <= 1'b1;
         // Write lock error
         if (setWle)
            errBits[Er1WleBit] <= 1'b1;
      end
   end

   assign er1 = rpEr1T'(errBits);

endmodule

`default_nettype wire

// File: rtl/rpFuncPkg.sv
////////////////////////////////////////////////////////////////////////////
// Function codes, command pulse bundle and timer loads
// Codes missing from the enumeration are decoded as illegal
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package rpFuncPkg;

   // Function codes, written together with GO
   typedef enum logic [4:0] {
      FnNop    = 5'd0,
      FnUnload = 5'd1,
      FnSeek   = 5'd2,
      FnRecal  = 5'd3,
      FnDrvClr = 5'd4,
      FnPreset = 5'd8,
      FnPakAck = 5'd9,
      FnWrite  = 5'd24,
      FnRead   = 5'd28
   } rpFuncT;

   // Pulses from the FSM to the status register
   typedef struct packed {
      logic drvClr;
      logic preset;
      logic pakAck;
      logic setAta;
      logic setLst;
      logic clrLst;
      logic goErr;
      logic spare;
   } rpCmdT;

   // Stand-in operation times, in clocks
   localparam int SeekCycles = 24;
   localparam int XferCycles = 40;
   localparam int TimerWidth = 6;

endpackage

`default_nettype wire

// File: rtl/rpOpTimer.sv
////////////////////////////////////////////////////////////////////////////
// Operation timer, stands in for seek and sector time
// The start cycle counts as the first tick
// A load of zero is not supported
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rpOpTimer
   import rpFuncPkg::*;
(
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  start,
   input  wire [TimerWidth-1:0] load,
   output logic                 done
);

   logic                  running;
   logic [TimerWidth-1:0] count;

   // Run flag
   always_ff @(posedge clk)
   begin
      if (rst)
         running <= 1'b0;
      else if (start)
         running <= 1'b1;
      else if (done)
         running <= 1'b0;
   end

   // Down counter
   always_ff @(posedge clk)
   begin
      if (start)
         count <= load - 1'b1;
      else if (running & (count != '0))
         count <= count - 1'b1;
   end

   // Expiry pulse, one clock
   assign done = running & (count == '0);

   // FSM must not restart a running timer
   assert property (@(posedge clk) disable iff (rst) start |-> !running);

endmodule

`default_nettype wire

// File: rtl/rpRegPkg.sv
////////////////////////////////////////////////////////////////////////////
// Register layouts of the drive as the controller reads them
// Only ER1 is modelled, so the composite error comes from it alone
// Reserved fields always read zero
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package rpRegPkg;

   // Error word bit positions
   localparam int Er1IlfBit = 0;
   localparam int Er1RmrBit = 2;
   localparam int Er1WleBit = 11;

   // Low status bits, not used by this drive
   localparam int DsZeroWidth = 6;

   // Drive status word, MSB first
   typedef struct packed {
      logic                   ata;
      logic                   err;
      logic                   pip;
      logic                   mol;
      logic                   wrl;
      logic                   lst;
      logic                   pgm;
      logic                   dpr;
      logic                   dry;
      logic                   vv;
      logic [DsZeroWidth-1:0] zero;
   } rpDsT;

   // First error word
   typedef struct packed {
      logic [3:0] rsvdHi;
      logic       wle;
      logic [7:0] rsvdMid;
      logic       rmr;
      logic       rsvdLo;
      logic       ilf;
   } rpEr1T;

endpackage

`default_nettype wire

// File: rtl/rpStatusReg.sv
////////////////////////////////////////////////////////////////////////////
// Drive status register (DS)
// ATA, LST and VV are state here, the rest pass through
// ERR is formed from ER1 only; PGM and the low bits read zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rpStatusReg
   import rpRegPkg::*, rpFuncPkg::*;
(
   input  wire        clk,
   input  wire        rst,
   input  wire        devReset,
   input  wire        clrAta,
   input  wire rpCmdT cmd,
   input  wire        mol,
   input  wire        wrl,
   input  wire        dpr,
   input  wire        pip,
   input  wire        dry,
   input  wire rpEr1T er1,
   output rpDsT       ds
);

   logic molQ;
   logic ataQ;
   logic lstQ;
   logic vvQ;
   logic dsErr;

   // Last media on-line, for edge detect
   always_ff @(posedge clk)
   begin
      if (rst)
         molQ <= 1'b0;
      else
         molQ <= mol;
   end

   // Composite error
   assign dsErr = (er1 != '0);

   ////////////////////////////////////////////////////////////////////////////
   // Attention
   ////////////////////////////////////////////////////////////////////////////

   // Clears first; sets on either edge of mol
   always_ff @(posedge clk)
   begin
      if (rst | devReset | clrAta | cmd.drvClr)
         ataQ <= 1'b0;
      else if (cmd.setAta | (mol != molQ) | cmd.goErr)
         ataQ <= 1'b1;
   end

   // Last sector transferred
   always_ff @(posedge clk)
   begin
      if (rst | devReset | cmd.clrLst)
         lstQ <= 1'b0;
      else if (cmd.setLst)
         lstQ <= 1'b1;
   end

   // Volume valid, lost only when pack comes on-line
   always_ff @(posedge clk)
   begin
      if (rst | (mol & ~molQ))
         vvQ <= 1'b0;
      else if ((cmd.preset | cmd.pakAck) & ~dsErr)
         vvQ <= 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Status word
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      ds      = '0;
      ds.ata  = ataQ;
      ds.err  = dsErr;
      ds.pip  = pip;
      ds.mol  = mol;
      ds.wrl  = wrl;
      ds.lst  = lstQ;
      ds.dpr  = dpr;
      ds.dry  = dry;
      ds.vv   = vvQ;
   end

   // A transfer never both starts and ends in one clock
   assert property (@(posedge clk) disable iff (rst) !(cmd.setLst && cmd.clrLst));

endmodule

`default_nettype wire

// File: sim/rpDriveTb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the drive top level
// Random function stream from a fixed seed, one operation per step
// Inputs change 1 ns after the rising edge, outputs are read 3 ns after it
// Busy writes are placed well inside an operation, never on its last cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rpDriveTb
   import rpRegPkg::*, rpFuncPkg::*;
();

   localparam int unsigned Seed          = 32'he20f617b;
   localparam int unsigned StepCount     = 400;
   localparam int unsigned TimeoutCycles = StepCount * (XferCycles + 16);

   // DUT inputs
   logic   clk;
   logic   rst;
   logic   devReset;
   logic   funcWrite;
   rpFuncT funcCode;
   logic   go;
   logic   clrAta;
   logic   mol;
   logic   wrl;
   logic   dpr;

   // DUT outputs
   wire rpDsT  ds;
   wire rpEr1T er1;

   // Reference state of the drive
   logic        mAta;
   logic        mLst;
   logic        mVv;
   logic [15:0] mEr1;

   int unsigned cycleCount;
   int unsigned errorCount;
   int unsigned checkCount;

   rpDrive rpDrive_i (
      .clk       (clk),
      .rst       (rst),
      .devReset  (devReset),
      .funcWrite (funcWrite),
      .funcCode  (funcCode),
      .go        (go),
      .clrAta    (clrAta),
      .mol       (mol),
      .wrl       (wrl),
      .dpr       (dpr),
      .ds        (ds),
      .er1       (er1)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Hang guard
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TimeoutCycles)
      begin
         $display("Timeout: the run hung, still busy after %0d cycles", cycleCount);
         $display("TEST FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // To the drive point of the next cycle
   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic expectBit(input string name, input logic got, input logic exp);
      checkCount++;
      if (got !== exp)
      begin
         errorCount++;
         $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic expectWord(input string name, input logic [15:0] got, input logic [15:0] exp);
      checkCount++;
      if (got !== exp)
      begin
         errorCount++;
         $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Codes the drive accepts, from the function table
   function automatic logic legalCode(input logic [4:0] code);
      case (code)
         5'd0, 5'd2, 5'd3, 5'd4, 5'd8, 5'd9, 5'd24, 5'd28: legalCode = 1'b1;
         default: legalCode = 1'b0;
      endcase
   endfunction

   // Mostly known codes, drive clear weighted up, sometimes any value
   function automatic logic [4:0] pickCode();
      int unsigned sel;
      sel = $urandom % 12;
      case (sel)
         0:       pickCode = FnNop;
         1:       pickCode = FnUnload;
         2:       pickCode = FnSeek;
         3:       pickCode = FnRecal;
         4, 5:    pickCode = FnDrvClr;
         6:       pickCode = FnPreset;
         7:       pickCode = FnPakAck;
         8:       pickCode = FnWrite;
         9:       pickCode = FnRead;
         default: pickCode = 5'($urandom);
      endcase
   endfunction

   // Whole status word and error word against the reference
   task automatic checkAll();
      #2;
      expectBit("ata", ds.ata, mAta);
      expectBit("err", ds.err, mEr1 != 16'h0);
      expectBit("pip", ds.pip, 1'b0);
      expectBit("mol", ds.mol, mol);
      expectBit("wrl", ds.wrl, wrl);
      expectBit("lst", ds.lst, mLst);
      expectBit("pgm", ds.pgm, 1'b0);
      expectBit("dpr", ds.dpr, dpr);
      expectBit("dry", ds.dry, 1'b1);
      expectBit("vv", ds.vv, mVv);
      expectWord("ds low bits", 16'(ds.zero), 16'h0);
      expectWord("er1", er1, mEr1);
   endtask

   // Effects of a decoded write on the reference state
   task automatic applyDecode(input logic [4:0] code, input logic goBit,
                              output logic opRuns, output logic opPos);
      opRuns = 1'b0;
      opPos  = 1'b0;
      if (goBit)
      begin
         if (mEr1 != 16'h0)
         begin
            // Error present, only drive clear runs
            if (code == FnDrvClr)
            begin
               mEr1 = 16'h0;
               mAta = 1'b0;
            end
            else
               mAta = 1'b1;
         end
         else if (!legalCode(code))
         begin
            mEr1[Er1IlfBit] = 1'b1;
            mAta            = 1'b1;
         end
         else if (code == FnSeek || code == FnRecal)
         begin
            opRuns = 1'b1;
            opPos  = 1'b1;
         end
         else if (code == FnDrvClr)
         begin
            mEr1 = 16'h0;
            mAta = 1'b0;
         end
         else if (code == FnPreset || code == FnPakAck)
            mVv = 1'b1;
         else if (code == FnRead || (code == FnWrite && !wrl))
         begin
            opRuns = 1'b1;
            mLst   = 1'b0;
         end
         else if (code == FnWrite)
         begin
            // Locked pack
            mEr1[Er1WleBit] = 1'b1;
            mAta            = 1'b1;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus steps
   ////////////////////////////////////////////////////////////////////////////

   // Either edge sets ATA, only the rising one drops VV
   task automatic toggleMol();
      mol = ~mol;
      if (mol)
         mVv = 1'b0;
      mAta = 1'b1;
      nextCycle();
      nextCycle();
   endtask

   task automatic pulseClrAta();
      clrAta = 1'b1;
      nextCycle();
      clrAta = 1'b0;
      mAta   = 1'b0;
      nextCycle();
   endtask

   // VV survives a device reset
   task automatic pulseDevReset();
      devReset = 1'b1;
      nextCycle();
      devReset = 1'b0;
      mAta     = 1'b0;
      mLst     = 1'b0;
      mEr1     = 16'h0;
      nextCycle();
   endtask

   task automatic issueFunction(input logic [4:0] code, input logic goBit,
                                input logic busyWrite);
      logic        opRuns;
      logic        opPos;
      int unsigned lowStart;
      logic [15:0] lowExp;
      funcCode  = rpFuncT'(code);
      go        = goBit;
      funcWrite = 1'b1;
      applyDecode(code, goBit, opRuns, opPos);
      nextCycle();
      funcWrite = 1'b0;
      go        = 1'b0;
      lowStart  = cycleCount;
      // First cycle after the strobe
      #2;
      expectBit("pip at start", ds.pip, opPos);
      expectBit("dry at start", ds.dry, ~opRuns);
      if (opRuns)
      begin
         // Transfers drop LST as they start, seeks leave it
         nextCycle();
         #2;
         expectBit("lst while busy", ds.lst, mLst);
         if (busyWrite)
         begin
            nextCycle();
            funcCode  = rpFuncT'(pickCode());
            go        = 1'b1;
            funcWrite = 1'b1;
            nextCycle();
            funcWrite       = 1'b0;
            go              = 1'b0;
            mEr1[Er1RmrBit] = 1'b1;
            mAta            = 1'b1;
         end
         while (ds.dry !== 1'b1)
            nextCycle();
         // Drive busy for the timer load plus one
         lowExp = opPos ? 16'(SeekCycles + 1) : 16'(XferCycles + 1);
         expectWord("dry low cycles", 16'(cycleCount - lowStart), lowExp);
         if (opPos)
            mAta = 1'b1;
         else
            mLst = 1'b1;
      end
      nextCycle();
      nextCycle();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [4:0] code;
      logic       goBit;
      logic       busyWrite;
      rst        = 1'b1;
      devReset   = 1'b0;
      funcWrite  = 1'b0;
      funcCode   = FnNop;
      go         = 1'b0;
      clrAta     = 1'b0;
      mol        = 1'b0;
      wrl        = 1'b0;
      dpr        = 1'b0;
      mAta       = 1'b0;
      mLst       = 1'b0;
      mVv        = 1'b0;
      mEr1       = 16'h0;
      cycleCount = 0;
      errorCount = 0;
      checkCount = 0;
      void'($urandom(Seed));

      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      // State right after reset
      checkAll();
      nextCycle();

      for (int step = 0; step < StepCount; step++)
      begin
         if (($urandom % 10) == 0)
            toggleMol();
         if (($urandom % 8) == 0)
         begin
            wrl = ~wrl;
            nextCycle();
         end
         if (($urandom % 16) == 0)
         begin
            dpr = ~dpr;
            nextCycle();
         end
         if (($urandom % 8) == 0)
            pulseClrAta();
         if (($urandom % 40) == 0)
            pulseDevReset();
         code      = pickCode();
         goBit     = (($urandom % 8) != 0);
         busyWrite = (($urandom % 6) == 0);
         issueFunction(code, goBit, busyWrite);
         checkAll();
         nextCycle();
      end

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire
